// ==== design/vc_router_pkg.sv ====
// VC router package with widths, FIFO depths, flit field types and config register map
package vc_router_pkg;

  // Virtual channel geometry
  localparam int NUM_VC   = 4;
  localparam int VC_IDX_W = 2;

  // Input FIFO depths, one VC gets more room
  localparam int VC_DEPTH      = 4;
  localparam int DEEP_VC_ID    = 0;
  localparam int DEEP_VC_DEPTH = 8;

  // Flit field widths
  localparam int TAG_W     = 6;
  localparam int PAYLOAD_W = 16;
  localparam int HDR_W     = VC_IDX_W + TAG_W;
  localparam int FLIT_W    = HDR_W + PAYLOAD_W;

  // Downstream buffer slots per VC
  localparam int CREDIT_W = 3;

  typedef logic [VC_IDX_W-1:0]  vc_idx_t;
  typedef logic [NUM_VC-1:0]    vc_mask_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [PAYLOAD_W-1:0] payload_t;
  // Header is {vc index, tag}
  typedef logic [HDR_W-1:0]     hdr_t;
  // Flit is {header, payload}
  typedef logic [FLIT_W-1:0]    flit_t;
  typedef logic [CREDIT_W-1:0]  credit_t;
  typedef logic [1:0]           cfg_addr_t;
  typedef logic [7:0]           cfg_data_t;

  // Reset value of every credit counter
  localparam credit_t DOWN_CREDITS = credit_t'(3);

  // Config register map
  typedef enum cfg_addr_t {
    CFG_VC_ENABLE = 2'd0,
    CFG_PRIO      = 2'd1
  } cfg_reg_e;

  // All VCs enabled out of reset
  localparam vc_mask_t VC_ENABLE_RST = '1;
  // Priority enable bit inside CFG_PRIO
  localparam int PRIO_EN_BIT = 7;

  // Field extraction helpers
  function automatic hdr_t flit_hdr(flit_t f);
    return f[FLIT_W-1 -: HDR_W];
  endfunction

  function automatic payload_t flit_payload(flit_t f);
    return f[PAYLOAD_W-1:0];
  endfunction

  function automatic vc_idx_t hdr_vc(hdr_t h);
    return h[HDR_W-1 -: VC_IDX_W];
  endfunction

endpackage

// ==== design/vc_input_fifo.sv ====
// Single-VC circular buffer FIFO holding whole flits with a valid flag and pop strobe
`timescale 1ns/1ns
module vc_input_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 push_i,
  input  vc_router_pkg::flit_t data_i,
  input  logic                 pop_i,
  output vc_router_pkg::flit_t data_o,
  output logic                 valid_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  vc_router_pkg::flit_t mem_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;
  logic                 do_push;
  logic                 do_pop;

  // Upstream honours credits, a full FIFO simply refuses the write
  assign do_push = push_i && (count_q != CNT_W'(DEPTH));
  // Pop on empty is ignored
  assign do_pop  = pop_i && (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the level
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Oldest entry shown at the head
  assign data_o  = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);

endmodule

// ==== design/vc_input_port.sv ====
// VC input port that splits arriving flits into per-VC header and payload FIFOs
`timescale 1ns/1ns
module vc_input_port (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  // Arriving link
  input  logic                                                 in_valid_i,
  input  vc_router_pkg::flit_t                                 in_flit_i,
  // Header pop from the SA stage
  input  logic                                                 sa_pop_i,
  input  vc_router_pkg::vc_mask_t                              sa_vc_oh_i,
  // Payload pop from the ST stage
  input  logic                                                 st_pop_i,
  input  vc_router_pkg::vc_mask_t                              st_vc_oh_i,
  // Per-VC heads toward allocator and output stage
  output vc_router_pkg::vc_mask_t                              hdr_valid_o,
  output vc_router_pkg::hdr_t     [vc_router_pkg::NUM_VC-1:0]  vc_hdr_o,
  output vc_router_pkg::payload_t [vc_router_pkg::NUM_VC-1:0]  vc_payload_o,
  // Credit back to the upstream sender
  output logic                                                 up_credit_valid_o,
  output vc_router_pkg::vc_idx_t                               up_credit_id_o
);

  vc_router_pkg::vc_mask_t push_oh;
  vc_router_pkg::vc_mask_t hdr_pop;
  vc_router_pkg::vc_mask_t pay_pop;
  vc_router_pkg::flit_t    hdr_head [vc_router_pkg::NUM_VC];
  vc_router_pkg::flit_t    pay_head [vc_router_pkg::NUM_VC];
  vc_router_pkg::vc_idx_t  credit_id_d;
  logic [vc_router_pkg::VC_IDX_W-1:0][vc_router_pkg::NUM_VC-1:0] id_mask;

  // VC index of the arriving flit turned into a one-hot push
  always_comb begin
    push_oh = '0;
    if (in_valid_i) begin
      push_oh[vc_router_pkg::hdr_vc(vc_router_pkg::flit_hdr(in_flit_i))] = 1'b1;
    end
  end

  // Headers leave at SA, payloads at ST
  assign hdr_pop = sa_pop_i ? sa_vc_oh_i : '0;
  assign pay_pop = st_pop_i ? st_vc_oh_i : '0;

  for (genvar vc = 0; vc < vc_router_pkg::NUM_VC; vc++) begin : gen_vc
    // Deep VC gets its own depth
    localparam int DEPTH = (vc == vc_router_pkg::DEEP_VC_ID) ?
                           vc_router_pkg::DEEP_VC_DEPTH : vc_router_pkg::VC_DEPTH;

    vc_input_fifo #(.DEPTH(DEPTH)) i_hdr_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_oh[vc]),
      .data_i  (in_flit_i),
      .pop_i   (hdr_pop[vc]),
      .data_o  (hdr_head[vc]),
      .valid_o (hdr_valid_o[vc])
    );

    // Payload FIFO level tracks the header FIFO, its valid is not needed
    vc_input_fifo #(.DEPTH(DEPTH)) i_pay_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_oh[vc]),
      .data_i  (in_flit_i),
      .pop_i   (pay_pop[vc]),
      .data_o  (pay_head[vc]),
      .valid_o ()
    );

    assign vc_hdr_o[vc]     = vc_router_pkg::flit_hdr(hdr_head[vc]);
    assign vc_payload_o[vc] = vc_router_pkg::flit_payload(pay_head[vc]);
  end

  // Bit b of the mask marks every VC whose index has bit b set
  for (genvar b = 0; b < vc_router_pkg::VC_IDX_W; b++) begin : gen_id_bit
    for (genvar v = 0; v < vc_router_pkg::NUM_VC; v++) begin : gen_id_vc
      assign id_mask[b][v] = ((v >> b) & 1) == 1;
    end
    assign credit_id_d[b] = |(st_vc_oh_i & id_mask[b]);
  end

  // Credit leaves together with the output flit
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      up_credit_valid_o <= 1'b0;
    end else begin
      up_credit_valid_o <= st_pop_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_pop_i) begin
      up_credit_id_o <= credit_id_d;
    end
  end

endmodule

// ==== design/vc_switch_alloc.sv ====
// Switch allocator picking one eligible VC per cycle by round-robin or strict priority
`timescale 1ns/1ns
module vc_switch_alloc (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  vc_router_pkg::vc_mask_t hdr_valid_i,
  input  vc_router_pkg::vc_mask_t credit_avail_i,
  input  vc_router_pkg::vc_mask_t vc_enable_i,
  input  logic                    prio_en_i,
  input  vc_router_pkg::vc_idx_t  prio_vc_i,
  // SA grant, same cycle
  output logic                    sa_pop_o,
  output vc_router_pkg::vc_mask_t sa_vc_oh_o,
  // ST grant, one cycle later
  output logic                    st_pop_o,
  output vc_router_pkg::vc_mask_t st_vc_oh_o
);

  vc_router_pkg::vc_mask_t eligible;
  vc_router_pkg::vc_idx_t  rr_ptr_q;
  vc_router_pkg::vc_idx_t  cand;
  vc_router_pkg::vc_idx_t  win_idx;
  logic                    found;

  always_comb begin
    // Needs a header, a downstream slot and the enable bit
    eligible = hdr_valid_i & credit_avail_i & vc_enable_i;
    found    = 1'b0;
    win_idx  = rr_ptr_q;
    cand     = rr_ptr_q;
    if (prio_en_i && eligible[prio_vc_i]) begin
      // Priority VC beats round-robin
      found   = 1'b1;
      win_idx = prio_vc_i;
    end else begin
      // Scan from the pointer, wrapping over all VCs
      for (int i = 0; i < vc_router_pkg::NUM_VC; i++) begin
        cand = vc_router_pkg::vc_idx_t'(int'(rr_ptr_q) + i);
        if (!found && eligible[cand]) begin
          found   = 1'b1;
          win_idx = cand;
        end
      end
    end
  end

  // Grant drives the header pop directly
  always_comb begin
    sa_vc_oh_o = '0;
    if (found) begin
      sa_vc_oh_o[win_idx] = 1'b1;
    end
  end

  assign sa_pop_o = found;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= '0;
      st_pop_o   <= 1'b0;
      st_vc_oh_o <= '0;
    end else begin
      // Next search starts one past the winner
      if (found) begin
        rr_ptr_q <= win_idx + 1'b1;
      end
      // SA to ST stage register
      st_pop_o   <= sa_pop_o;
      st_vc_oh_o <= sa_vc_oh_o;
    end
  end

endmodule

// ==== design/vc_credit_counter.sv ====
// Per-VC downstream credit counters, taken on grant and refilled by returned credits
`timescale 1ns/1ns
module vc_credit_counter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Grant consumes one slot
  input  logic                    take_i,
  input  vc_router_pkg::vc_mask_t take_vc_oh_i,
  // Downstream frees one slot
  input  logic                    ret_valid_i,
  input  vc_router_pkg::vc_idx_t  ret_id_i,
  output vc_router_pkg::vc_mask_t credit_avail_o
);

  for (genvar v = 0; v < vc_router_pkg::NUM_VC; v++) begin : gen_cnt
    vc_router_pkg::credit_t cnt_q;
    logic                   take;
    logic                   ret;

    assign take = take_i && take_vc_oh_i[v];
    assign ret  = ret_valid_i && (ret_id_i == vc_router_pkg::vc_idx_t'(v));

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q <= vc_router_pkg::DOWN_CREDITS;
      end else if (take && !ret) begin
        // Never wraps below zero
        if (cnt_q != '0) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end else if (ret && !take) begin
        // Saturates at the downstream buffer size
        if (cnt_q != vc_router_pkg::DOWN_CREDITS) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end

    // Any slot left lets the VC compete
    assign credit_avail_o[v] = (cnt_q != '0);
  end

endmodule

// ==== design/vc_cfg_regs.sv ====
// Config register block with VC enable mask and strict-priority VC setting
`timescale 1ns/1ns
module vc_cfg_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     cfg_we_i,
  input  vc_router_pkg::cfg_addr_t cfg_addr_i,
  input  vc_router_pkg::cfg_data_t cfg_wdata_i,
  output vc_router_pkg::cfg_data_t cfg_rdata_o,
  // Allocator steering
  output vc_router_pkg::vc_mask_t  vc_enable_o,
  output logic                     prio_en_o,
  output vc_router_pkg::vc_idx_t   prio_vc_o
);

  vc_router_pkg::vc_mask_t vc_enable_q;
  logic                    prio_en_q;
  vc_router_pkg::vc_idx_t  prio_vc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vc_enable_q <= vc_router_pkg::VC_ENABLE_RST;
      prio_en_q   <= 1'b0;
      prio_vc_q   <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        vc_router_pkg::CFG_VC_ENABLE: begin
          vc_enable_q <= cfg_wdata_i[vc_router_pkg::NUM_VC-1:0];
        end
        vc_router_pkg::CFG_PRIO: begin
          prio_en_q <= cfg_wdata_i[vc_router_pkg::PRIO_EN_BIT];
          prio_vc_q <= cfg_wdata_i[vc_router_pkg::VC_IDX_W-1:0];
        end
        // Unmapped addresses drop the write
        default: ;
      endcase
    end
  end

  // Combinational readback, unmapped addresses read zero
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      vc_router_pkg::CFG_VC_ENABLE: begin
        cfg_rdata_o[vc_router_pkg::NUM_VC-1:0] = vc_enable_q;
      end
      vc_router_pkg::CFG_PRIO: begin
        cfg_rdata_o[vc_router_pkg::PRIO_EN_BIT]        = prio_en_q;
        cfg_rdata_o[vc_router_pkg::VC_IDX_W-1:0] = prio_vc_q;
      end
      default: ;
    endcase
  end

  assign vc_enable_o = vc_enable_q;
  assign prio_en_o   = prio_en_q;
  assign prio_vc_o   = prio_vc_q;

endmodule

// ==== design/vc_router_unit.sv ====
// VC router port top with input FIFOs, allocator, credits, config and ST output register
`timescale 1ns/1ns
module vc_router_unit (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Input link
  input  logic                     in_valid_i,
  input  vc_router_pkg::flit_t     in_flit_i,
  // Credit back upstream
  output logic                     up_credit_valid_o,
  output vc_router_pkg::vc_idx_t   up_credit_id_o,
  // Output link
  output logic                     out_valid_o,
  output vc_router_pkg::flit_t     out_flit_o,
  // Credit from downstream
  input  logic                     down_credit_valid_i,
  input  vc_router_pkg::vc_idx_t   down_credit_id_i,
  // Config port
  input  logic                     cfg_we_i,
  input  vc_router_pkg::cfg_addr_t cfg_addr_i,
  input  vc_router_pkg::cfg_data_t cfg_wdata_i,
  output vc_router_pkg::cfg_data_t cfg_rdata_o
);

  vc_router_pkg::vc_mask_t                             hdr_valid;
  vc_router_pkg::hdr_t     [vc_router_pkg::NUM_VC-1:0] vc_hdr;
  vc_router_pkg::payload_t [vc_router_pkg::NUM_VC-1:0] vc_payload;
  logic                                                sa_pop;
  vc_router_pkg::vc_mask_t                             sa_vc_oh;
  logic                                                st_pop;
  vc_router_pkg::vc_mask_t                             st_vc_oh;
  vc_router_pkg::vc_mask_t                             credit_avail;
  vc_router_pkg::vc_mask_t                             vc_enable;
  logic                                                prio_en;
  vc_router_pkg::vc_idx_t                              prio_vc;
  vc_router_pkg::hdr_t                                 sa_hdr;
  vc_router_pkg::hdr_t                                 st_hdr_q;
  vc_router_pkg::payload_t                             st_payload;

  vc_input_port i_input_port (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .in_valid_i        (in_valid_i),
    .in_flit_i         (in_flit_i),
    .sa_pop_i          (sa_pop),
    .sa_vc_oh_i        (sa_vc_oh),
    .st_pop_i          (st_pop),
    .st_vc_oh_i        (st_vc_oh),
    .hdr_valid_o       (hdr_valid),
    .vc_hdr_o          (vc_hdr),
    .vc_payload_o      (vc_payload),
    .up_credit_valid_o (up_credit_valid_o),
    .up_credit_id_o    (up_credit_id_o)
  );

  vc_switch_alloc i_switch_alloc (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .hdr_valid_i    (hdr_valid),
    .credit_avail_i (credit_avail),
    .vc_enable_i    (vc_enable),
    .prio_en_i      (prio_en),
    .prio_vc_i      (prio_vc),
    .sa_pop_o       (sa_pop),
    .sa_vc_oh_o     (sa_vc_oh),
    .st_pop_o       (st_pop),
    .st_vc_oh_o     (st_vc_oh)
  );

  // Credits are taken at the SA grant
  vc_credit_counter i_credit_counter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .take_i         (sa_pop),
    .take_vc_oh_i   (sa_vc_oh),
    .ret_valid_i    (down_credit_valid_i),
    .ret_id_i       (down_credit_id_i),
    .credit_avail_o (credit_avail)
  );

  vc_cfg_regs i_cfg_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .vc_enable_o (vc_enable),
    .prio_en_o   (prio_en),
    .prio_vc_o   (prio_vc)
  );

  // One-hot selects of the granted header and payload
  always_comb begin
    sa_hdr     = '0;
    st_payload = '0;
    for (int v = 0; v < vc_router_pkg::NUM_VC; v++) begin
      if (sa_vc_oh[v]) begin
        sa_hdr = sa_hdr | vc_hdr[v];
      end
      if (st_vc_oh[v]) begin
        st_payload = st_payload | vc_payload[v];
      end
    end
  end

  // Header popped at SA waits here for its payload
  always_ff @(posedge clk_i) begin
    if (sa_pop) begin
      st_hdr_q <= sa_hdr;
    end
  end

  // ST output register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= st_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_pop) begin
      out_flit_o <= {st_hdr_q, st_payload};
    end
  end

endmodule

// ==== tb/vc_router_unit_tb.sv ====
// Testbench for the VC router port driven from a command file against a queue-based model
`timescale 1ns/1ns
module vc_router_unit_tb;

  // Cycle limits for every wait loop
  localparam int CREDIT_WAIT_MAX = 500;
  localparam int DRAIN_WAIT_MAX  = 2000;

  logic                     clk_i = 1'b0;
  logic                     rst_n_i;
  logic                     in_valid_i;
  vc_router_pkg::flit_t     in_flit_i;
  logic                     up_credit_valid_o;
  vc_router_pkg::vc_idx_t   up_credit_id_o;
  logic                     out_valid_o;
  vc_router_pkg::flit_t     out_flit_o;
  logic                     down_credit_valid_i;
  vc_router_pkg::vc_idx_t   down_credit_id_i;
  logic                     cfg_we_i;
  vc_router_pkg::cfg_addr_t cfg_addr_i;
  vc_router_pkg::cfg_data_t cfg_wdata_i;
  vc_router_pkg::cfg_data_t cfg_rdata_o;

  // Expected flits per VC plus exact expectations from E lines
  vc_router_pkg::flit_t     exp_q [vc_router_pkg::NUM_VC][$];
  vc_router_pkg::flit_t     exact_q [$];
  // Downstream credits waiting to be driven one per cycle
  vc_router_pkg::vc_idx_t   pend_q [$];
  int                       up_cred [vc_router_pkg::NUM_VC];
  int                       down_cred [vc_router_pkg::NUM_VC];
  int                       sent_cnt [vc_router_pkg::NUM_VC];
  int                       back_cnt [vc_router_pkg::NUM_VC];
  bit                       hold_credits;
  logic [8*32-1:0]          test_name;
  logic [31:0]              lfsr_q;
  vc_router_pkg::cfg_data_t rdata_seen;

  vc_router_unit i_dut (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .in_valid_i          (in_valid_i),
    .in_flit_i           (in_flit_i),
    .up_credit_valid_o   (up_credit_valid_o),
    .up_credit_id_o      (up_credit_id_o),
    .out_valid_o         (out_valid_o),
    .out_flit_o          (out_flit_o),
    .down_credit_valid_i (down_credit_valid_i),
    .down_credit_id_i    (down_credit_id_i),
    .cfg_we_i            (cfg_we_i),
    .cfg_addr_i          (cfg_addr_i),
    .cfg_wdata_i         (cfg_wdata_i),
    .cfg_rdata_o         (cfg_rdata_o)
  );

  // 20 ns clock
  always #10 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_flit(input vc_router_pkg::flit_t exp, input vc_router_pkg::flit_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %0s: expected flit %h, actual %h", test_name, exp, act));
    end
  endtask

  task automatic check_credit_id(input vc_router_pkg::vc_idx_t exp,
                                 input vc_router_pkg::vc_idx_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %0s: expected credit VC %0d, actual %0d",
                          test_name, exp, act));
    end
  endtask

  task automatic check_cfg(input vc_router_pkg::cfg_data_t exp,
                           input vc_router_pkg::cfg_data_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %0s: expected config data %h, actual %h",
                          test_name, exp, act));
    end
  endtask

  task automatic check_count(input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("[ERROR] %0s: expected count %0d, actual %0d", test_name, exp, act));
    end
  endtask

  // Flit is {vc, tag, payload}
  function automatic vc_router_pkg::flit_t make_flit(input vc_router_pkg::vc_idx_t vc,
                                                     input vc_router_pkg::tag_t tag,
                                                     input vc_router_pkg::payload_t pl);
    return {vc, tag, pl};
  endfunction

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
  endtask

  // Queue a downstream credit
  // Model count saturates like the buffer
  task automatic return_credit(input vc_router_pkg::vc_idx_t vc);
    pend_q.push_back(vc);
    if (down_cred[vc] < int'(vc_router_pkg::DOWN_CREDITS)) begin
      down_cred[vc]++;
    end
  endtask

  // Output side sampled at the falling edge
  task automatic observe_outputs();
    vc_router_pkg::vc_idx_t vc;
    vc_router_pkg::flit_t   exp;
    rdata_seen = cfg_rdata_o;
    if (rst_n_i) begin
      if (out_valid_o) begin
        vc = out_flit_o[vc_router_pkg::FLIT_W-1 -: vc_router_pkg::VC_IDX_W];
        if (!up_credit_valid_o) begin
          abort_run("Output flit left without an upstream credit pulse");
        end
        if (exp_q[vc].size() == 0) begin
          abort_run("Output flit on a VC that has no flit queued");
        end
        exp = exp_q[vc].pop_front();
        check_flit(exp, out_flit_o);
        // Credit names the VC of the expected flit
        check_credit_id(exp[vc_router_pkg::FLIT_W-1 -: vc_router_pkg::VC_IDX_W],
                        up_credit_id_o);
        if (exact_q.size() > 0) begin
          exp = exact_q.pop_front();
          check_flit(exp, out_flit_o);
        end
        if (down_cred[vc] == 0) begin
          abort_run("Output flit sent on a VC with no downstream credit");
        end
        down_cred[vc]--;
        // Downstream frees the slot at once unless held back
        if (!hold_credits) begin
          return_credit(vc);
        end
      end
      // Each returned credit frees one input FIFO slot for the sender
      if (up_credit_valid_o) begin
        up_cred[up_credit_id_o]++;
        back_cnt[up_credit_id_o]++;
      end
    end
  endtask

  // Every cycle passes here
  // Strobes drop at the rising edge
  task automatic step_cycle();
    @(negedge clk_i);
    observe_outputs();
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    cfg_we_i   <= 1'b0;
    if (pend_q.size() > 0) begin
      down_credit_valid_i <= 1'b1;
      down_credit_id_i    <= pend_q.pop_front();
    end else begin
      down_credit_valid_i <= 1'b0;
    end
  endtask

  task automatic send_flit(input vc_router_pkg::vc_idx_t vc, input vc_router_pkg::tag_t tag,
                           input vc_router_pkg::payload_t pl);
    int guard;
    guard = 0;
    // Sender respects the input FIFO credits
    while (up_cred[vc] == 0) begin
      step_cycle();
      guard++;
      if (guard > CREDIT_WAIT_MAX) begin
        abort_run("Timed out waiting for an upstream credit before sending a flit");
      end
    end
    step_cycle();
    in_valid_i <= 1'b1;
    in_flit_i  <= make_flit(vc, tag, pl);
    exp_q[vc].push_back(make_flit(vc, tag, pl));
    up_cred[vc]--;
    sent_cnt[vc]++;
  endtask

  // Random payloads and idle gaps of 0 to 3 cycles
  task automatic send_burst(input vc_router_pkg::vc_idx_t vc, input int count);
    logic [31:0] bits;
    int          i;
    for (i = 0; i < count; i++) begin
      take_bits(16, bits);
      send_flit(vc, vc_router_pkg::tag_t'(i), vc_router_pkg::payload_t'(bits));
      take_bits(2, bits);
      repeat (int'(bits[1:0])) step_cycle();
    end
  endtask

  task automatic write_cfg(input vc_router_pkg::cfg_addr_t addr,
                           input vc_router_pkg::cfg_data_t data);
    step_cycle();
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
  endtask

  // Combinational readback captured at the next falling edge
  task automatic read_cfg(input vc_router_pkg::cfg_addr_t addr,
                          input vc_router_pkg::cfg_data_t exp);
    step_cycle();
    cfg_addr_i <= addr;
    step_cycle();
    check_cfg(exp, rdata_seen);
  endtask

  // Wait until every queued flit, expectation and credit is gone
  task automatic drain_all();
    int guard;
    int v;
    bit busy;
    guard = 0;
    busy  = 1'b1;
    while (busy) begin
      busy = (exact_q.size() != 0) || (pend_q.size() != 0);
      for (v = 0; v < vc_router_pkg::NUM_VC; v++) begin
        if (exp_q[v].size() != 0) begin
          busy = 1'b1;
        end
      end
      if (busy) begin
        step_cycle();
        guard++;
        if (guard > DRAIN_WAIT_MAX) begin
          abort_run("Timed out waiting for queued flits to leave the output link");
        end
      end
    end
    // Last credit still needs its sampling edge
    step_cycle();
    step_cycle();
  endtask

  task automatic expect_fields(input int got, input int want);
    if (got != want) begin
      abort_run("Malformed command line in the stimulus file");
    end
  endtask

  task automatic run_command(input int fd, input logic [7:0] cmd);
    logic [31:0]      a0;
    logic [31:0]      a1;
    logic [31:0]      a2;
    logic [8*128-1:0] rest;
    int               code;
    case (cmd)
      "#": code = $fgets(rest, fd);
      "T": begin
        code = $fscanf(fd, "%s", test_name);
        expect_fields(code, 1);
      end
      "F", "E": begin
        code = $fscanf(fd, "%h %h %h", a0, a1, a2);
        expect_fields(code, 3);
        if (cmd == "F") begin
          send_flit(vc_router_pkg::vc_idx_t'(a0), vc_router_pkg::tag_t'(a1),
                    vc_router_pkg::payload_t'(a2));
        end else begin
          exact_q.push_back(make_flit(vc_router_pkg::vc_idx_t'(a0), vc_router_pkg::tag_t'(a1),
                                      vc_router_pkg::payload_t'(a2)));
        end
      end
      "B", "W", "R", "L": begin
        code = $fscanf(fd, "%h %h", a0, a1);
        expect_fields(code, 2);
        case (cmd)
          "B": send_burst(vc_router_pkg::vc_idx_t'(a0), int'(a1));
          "W": write_cfg(vc_router_pkg::cfg_addr_t'(a0), vc_router_pkg::cfg_data_t'(a1));
          "R": read_cfg(vc_router_pkg::cfg_addr_t'(a0), vc_router_pkg::cfg_data_t'(a1));
          default: check_count(int'(a1), exp_q[vc_router_pkg::vc_idx_t'(a0)].size());
        endcase
      end
      "C", "N", "H": begin
        code = $fscanf(fd, "%h", a0);
        expect_fields(code, 1);
        case (cmd)
          "C": return_credit(vc_router_pkg::vc_idx_t'(a0));
          "N": repeat (int'(a0)) step_cycle();
          default: hold_credits = (a0 != '0);
        endcase
      end
      "Q": drain_all();
      default: abort_run("Unknown command letter in the stimulus file");
    endcase
  endtask

  initial begin
    int          fd;
    int          code;
    int          v;
    logic [7:0]  cmd;
    bit          done;
    rst_n_i             <= 1'b0;
    in_valid_i          <= 1'b0;
    in_flit_i           <= '0;
    down_credit_valid_i <= 1'b0;
    down_credit_id_i    <= '0;
    cfg_we_i            <= 1'b0;
    cfg_addr_i          <= '0;
    cfg_wdata_i         <= '0;
    lfsr_q       = 32'he7cc_c755;
    hold_credits = 1'b0;
    test_name    = "reset";
    rdata_seen   = '0;
    // Upstream credits equal the input FIFO depths
    for (v = 0; v < vc_router_pkg::NUM_VC; v++) begin
      up_cred[v]   = (v == vc_router_pkg::DEEP_VC_ID) ? vc_router_pkg::DEEP_VC_DEPTH
                                                      : vc_router_pkg::VC_DEPTH;
      down_cred[v] = int'(vc_router_pkg::DOWN_CREDITS);
      sent_cnt[v]  = 0;
      back_cnt[v]  = 0;
    end
    repeat (16) step_cycle();
    rst_n_i <= 1'b1;
    fd = $fopen("tb/vc_router_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file tb/vc_router_stimulus.txt");
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        run_command(fd, cmd);
      end
    end
    $fclose(fd);
    drain_all();
    // One upstream credit for every flit sent
    test_name = "credit_totals";
    for (v = 0; v < vc_router_pkg::NUM_VC; v++) begin
      check_count(sent_cnt[v], back_cnt[v]);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== tb/vc_router_stimulus.txt ====
# All fields hex: F/E vc tag payload, B vc count, C vc, W/R addr data, L vc queued, N cycles
# T test name, H 1 holds or 0 resumes downstream credit return, Q drains all queues
T reset_values
R 0 0f
R 1 00
R 2 00
T order_no_loss
B 0 8
B 1 6
B 2 5
B 3 7
F 0 3f ffff
F 2 01 0001
B 0 8
Q
T credit_backpressure
H 1
F 1 10 1000
F 1 11 1001
F 1 12 1002
F 1 13 1003
F 1 14 1004
N 20
L 1 2
H 0
C 1
C 1
C 1
Q
T vc_enable
W 0 0b
R 0 0b
F 2 20 2000
F 2 21 2001
F 1 22 2002
E 1 22 2002
E 2 20 2000
E 2 21 2001
N 20
L 2 2
W 0 0f
Q
T strict_priority
W 1 83
R 1 83
H 1
F 1 30 3000
F 1 31 3001
F 1 32 3002
F 3 30 3100
F 3 31 3101
F 3 32 3102
N 20
L 1 0
L 3 0
W 0 05
F 1 33 3003
F 1 34 3004
F 3 33 3103
F 3 34 3104
H 0
C 1
C 1
C 1
C 3
C 3
C 3
N 10
L 1 2
L 3 2
E 3 33 3103
E 3 34 3104
E 1 33 3003
E 1 34 3004
W 0 0f
Q
T cfg_readback
W 1 02
R 1 02
W 3 ff
R 3 00
W 0 05
R 0 05
W 0 0f
R 0 0f
W 1 00
R 1 00

// ==== verilog.f ====
design/vc_router_pkg.sv
design/vc_input_fifo.sv
design/vc_input_port.sv
design/vc_switch_alloc.sv
design/vc_credit_counter.sv
design/vc_cfg_regs.sv
design/vc_router_unit.sv
tb/vc_router_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the VC router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module vc_router_unit_tb -f verilog.f -Mdir obj_dir

# The simulator exits nonzero on a fatal check, the search below decides the result
sim_out=$(./obj_dir/Vvc_router_unit_tb 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qF "Test completed successfully"; then
  exit 0
else
  exit 1
fi
